/* hw/lm80c_bus_pkg.sv */
package lm80c_bus_pkg;

	// z80 style cpu bus
	localparam int CPU_ADDR_W = 16;
	localparam int CPU_DATA_W = 8;

	typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
	typedef logic [CPU_DATA_W-1:0] cpu_data_t;

	// i/o space only decodes the low address byte
	localparam int IO_PORT_W = 8;

	// debug led latch
	localparam logic [IO_PORT_W-1:0] LED_PORT = 8'd255;

	// cpu may only write this slice of system ram
	localparam cpu_addr_t RAM_WIN_LO = 16'h8000;
	localparam cpu_addr_t RAM_WIN_HI = 16'hBFFF;

	// ram clocks per cpu clock enable
	localparam int CPU_ENA_PERIOD = 8;

endpackage

/* hw/lm80c_mem_pkg.sv */
package lm80c_mem_pkg;

	// system ram is byte wide
	localparam int MEM_DATA_W = 8;

	typedef logic [MEM_DATA_W-1:0] mem_data_t;

	// value left in every cell after an erase sweep
	localparam mem_data_t ERASE_VALUE = 8'h00;

	// which requester owns the registered ram access
	// ordered by priority, download first
	typedef enum logic [1:0] {
		SRC_DL    = 2'd0,
		SRC_ERASE = 2'd1,
		SRC_CPU   = 2'd2
	} mem_src_e;

endpackage

/* hw/mem_port_if.sv */
`timescale 1ns/1ps

// one ram request port into the arbiter
// no ready line, the owner holds its request while it has priority
// the arbiter tags each registered access with a mem_src_e value
interface mem_port_if #(
	parameter int RAM_ADDR_W = 16
) ();

	logic [RAM_ADDR_W-1:0] addr;
	lm80c_mem_pkg::mem_data_t wdata;
	logic wr;
	logic rd;

	// registered, two cycles behind the request
	lm80c_mem_pkg::mem_data_t rdata;

	// eraser or cpu side
	modport requester (
		output addr,
		output wdata,
		output wr,
		output rd,
		input  rdata
	);

	// ram side
	modport arbiter (
		input  addr,
		input  wdata,
		input  wr,
		input  rd,
		output rdata
	);

endinterface

/* hw/system_control.sv */
`timescale 1ns/1ps

module system_control (
	input  logic ram_clock,
	input  logic RESET,
	input  logic boot_done_i,
	input  logic reset_key_i,
	input  logic dl_active_i,
	input  logic erasing_i,
	output logic cpu_ena_o,
	output logic cpu_reset_o,
	output logic cpu_wait_o
);

	localparam int CNT_W = $clog2(lm80c_bus_pkg::CPU_ENA_PERIOD);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(lm80c_bus_pkg::CPU_ENA_PERIOD - 1);

	logic [CNT_W-1:0] ena_cnt;

	// free running divider, restarts at zero on reset
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			ena_cnt <= '0;
		end else if (ena_cnt == CNT_LAST) begin
			ena_cnt <= '0;
		end else begin
			ena_cnt <= ena_cnt + 1'b1;
		end
	end

	// first enable lands right after reset drops
	assign cpu_ena_o = (ena_cnt == '0);

	// cpu held in reset while booting, on the reset key, or during erase
	assign cpu_reset_o = ~boot_done_i | reset_key_i | erasing_i;

	// cpu stalled whenever someone else owns the ram
	assign cpu_wait_o = ~boot_done_i | dl_active_i | erasing_i;

	// enables are single cycle pulses
	a_ena_pulse: assert property (@(posedge ram_clock) disable iff (RESET)
		cpu_ena_o |=> !cpu_ena_o);

endmodule

/* hw/ram_eraser.sv */
`timescale 1ns/1ps

module ram_eraser #(
	parameter int RAM_ADDR_W = 16
) (
	input  logic ram_clock,
	input  logic RESET,
	input  logic erase_trigger_i,
	output logic erasing_o,
	mem_port_if.requester mem
);

	logic trig_q;
	logic trig_rise;
	logic erasing_q;
	logic [RAM_ADDR_W-1:0] addr_q;

	assign trig_rise = erase_trigger_i & ~trig_q;

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			trig_q    <= 1'b0;
			erasing_q <= 1'b0;
			addr_q    <= '0;
		end else begin
			trig_q <= erase_trigger_i;
			if (erasing_q) begin
				// one cell per clock, stop after the top address
				addr_q <= addr_q + 1'b1;
				if (addr_q == '1) begin
					erasing_q <= 1'b0;
				end
			end else if (trig_rise) begin
				// trigger while busy is ignored
				erasing_q <= 1'b1;
				addr_q    <= '0;
			end
		end
	end

	assign erasing_o = erasing_q;

	// write only, the fill never needs read data back
	assign mem.addr  = addr_q;
	assign mem.wdata = lm80c_mem_pkg::ERASE_VALUE;
	assign mem.wr    = erasing_q;
	assign mem.rd    = 1'b0;

	// sweep starts at zero and steps by one with no gaps
	a_sweep: assert property (@(posedge ram_clock) disable iff (RESET)
		mem.wr |-> erasing_o &&
			($past(mem.wr) ? mem.addr == $past(mem.addr) + 1'b1 : mem.addr == '0));

endmodule

/* hw/sysram_arbiter.sv */
`timescale 1ns/1ps

module sysram_arbiter #(
	parameter int RAM_ADDR_W = 16
) (
	input  logic ram_clock,
	input  logic dl_active_i,
	input  logic dl_wr_i,
	input  logic [RAM_ADDR_W-1:0] dl_addr_i,
	input  lm80c_bus_pkg::cpu_data_t dl_data_i,
	mem_port_if.arbiter erase_port,
	mem_port_if.arbiter cpu_port
);

	localparam int RAM_DEPTH = 2 ** RAM_ADDR_W;

	// stage 1, registered winner
	lm80c_mem_pkg::mem_src_e src_q;
	logic [RAM_ADDR_W-1:0] addr_q;
	lm80c_mem_pkg::mem_data_t wdata_q;
	logic wr_q;
	logic rd_q;

	// stage 2, ram array and its output register
	lm80c_mem_pkg::mem_data_t ram [RAM_DEPTH];
	lm80c_mem_pkg::mem_data_t rdata_q;

	logic erase_req;

	// eraser only ever writes, but take either strobe as a request
	assign erase_req = erase_port.wr | erase_port.rd;

	// download beats eraser beats cpu
	always_ff @(posedge ram_clock) begin
		if (dl_active_i) begin
			src_q   <= lm80c_mem_pkg::SRC_DL;
			addr_q  <= dl_addr_i;
			wdata_q <= dl_data_i;
			wr_q    <= dl_wr_i;
			rd_q    <= 1'b0;
		end else if (erase_req) begin
			src_q   <= lm80c_mem_pkg::SRC_ERASE;
			addr_q  <= erase_port.addr;
			wdata_q <= erase_port.wdata;
			wr_q    <= erase_port.wr;
			rd_q    <= erase_port.rd;
		end else begin
			// cpu is the idle default, its strobes decide if anything happens
			src_q   <= lm80c_mem_pkg::SRC_CPU;
			addr_q  <= cpu_port.addr;
			wdata_q <= cpu_port.wdata;
			wr_q    <= cpu_port.wr;
			rd_q    <= cpu_port.rd;
		end
	end

	always_ff @(posedge ram_clock) begin
		if (wr_q) begin
			ram[addr_q] <= wdata_q;
		end
		// read data holds between reads
		if (rd_q) begin
			rdata_q <= ram[addr_q];
		end
	end

	// both requesters see the same output register
	assign erase_port.rdata = rdata_q;
	assign cpu_port.rdata   = rdata_q;

	// a cpu write must never land in ram while a download runs
	a_no_cpu_wr_in_dl: assert property (@(posedge ram_clock)
		(wr_q && src_q == lm80c_mem_pkg::SRC_CPU) |-> !dl_active_i);

endmodule

/* hw/io_decoder.sv */
`timescale 1ns/1ps

module io_decoder #(
	parameter int RAM_ADDR_W = 16
) (
	input  logic ram_clock,
	input  logic cpu_reset_i,
	input  lm80c_bus_pkg::cpu_addr_t cpu_addr_i,
	input  lm80c_bus_pkg::cpu_data_t cpu_dout_i,
	input  logic cpu_rd_i,
	input  logic cpu_wr_i,
	input  logic cpu_mreq_i,
	input  logic cpu_iorq_i,
	output lm80c_bus_pkg::cpu_data_t cpu_din_o,
	output logic led_o,
	mem_port_if.requester mem
);

	logic io_cycle;
	logic in_window;

	// registered decode
	logic led_sel_q;
	logic io_sel_q;
	logic win_q;

	// registered memory request
	logic [RAM_ADDR_W-1:0] mem_addr_q;
	lm80c_bus_pkg::cpu_data_t mem_wdata_q;
	logic mem_wr_q;
	logic mem_rd_q;

	lm80c_bus_pkg::cpu_data_t led_latch;
	lm80c_bus_pkg::cpu_data_t din_q;

	assign io_cycle  = cpu_iorq_i & ~cpu_mreq_i;
	assign in_window = (cpu_addr_i >= lm80c_bus_pkg::RAM_WIN_LO) &&
		(cpu_addr_i <= lm80c_bus_pkg::RAM_WIN_HI);

	always_ff @(posedge ram_clock) begin
		if (cpu_reset_i) begin
			led_sel_q <= 1'b0;
			io_sel_q  <= 1'b0;
			win_q     <= 1'b0;
			mem_wr_q  <= 1'b0;
			mem_rd_q  <= 1'b0;
		end else begin
			// only the low address byte names the port
			led_sel_q <= io_cycle &&
				(cpu_addr_i[lm80c_bus_pkg::IO_PORT_W-1:0] == lm80c_bus_pkg::LED_PORT);
			io_sel_q  <= io_cycle;
			win_q     <= cpu_mreq_i & in_window;
			mem_wr_q  <= cpu_wr_i & cpu_mreq_i;
			mem_rd_q  <= cpu_rd_i & cpu_mreq_i;
		end
	end

	// payload, no reset
	always_ff @(posedge ram_clock) begin
		mem_addr_q  <= cpu_addr_i[RAM_ADDR_W-1:0];
		mem_wdata_q <= cpu_dout_i;
	end

	// writes outside 8000..bfff are dropped, rom area stays intact
	assign mem.addr  = mem_addr_q;
	assign mem.wdata = mem_wdata_q;
	assign mem.wr    = mem_wr_q & win_q;
	assign mem.rd    = mem_rd_q;

	// led latch, cleared whenever the cpu sits in reset
	always_ff @(posedge ram_clock) begin
		if (cpu_reset_i) begin
			led_latch <= '0;
		end else if (led_sel_q && cpu_wr_i) begin
			led_latch <= cpu_dout_i;
		end
	end

	assign led_o = (led_latch != '0);

	// read mux, sampled only while rd is up
	always_ff @(posedge ram_clock) begin
		if (cpu_rd_i) begin
			if (led_sel_q) begin
				din_q <= led_latch;
			end else if (io_sel_q) begin
				// other peripherals are not present
				din_q <= '0;
			end else begin
				din_q <= mem.rdata;
			end
		end
	end

	assign cpu_din_o = din_q;

endmodule

/* hw/lm80c_core.sv */
`timescale 1ns/1ps

module lm80c_core #(
	parameter int RAM_ADDR_W = 16
) (
	input  logic ram_clock,
	input  logic RESET,
	input  lm80c_bus_pkg::cpu_addr_t cpu_addr_i,
	input  lm80c_bus_pkg::cpu_data_t cpu_dout_i,
	input  logic cpu_rd_i,
	input  logic cpu_wr_i,
	input  logic cpu_mreq_i,
	input  logic cpu_iorq_i,
	input  logic dl_active_i,
	input  logic dl_wr_i,
	input  logic [RAM_ADDR_W-1:0] dl_addr_i,
	input  lm80c_bus_pkg::cpu_data_t dl_data_i,
	input  logic boot_done_i,
	input  logic reset_key_i,
	input  logic erase_trigger_i,
	output lm80c_bus_pkg::cpu_data_t cpu_din_o,
	output logic cpu_ena_o,
	output logic cpu_reset_o,
	output logic cpu_wait_o,
	output logic erasing_o,
	output logic led_o
);

	logic erasing;
	logic cpu_reset;

	mem_port_if #(.RAM_ADDR_W(RAM_ADDR_W)) erase_port ();
	mem_port_if #(.RAM_ADDR_W(RAM_ADDR_W)) cpu_port ();

	system_control u_system_control (
		.ram_clock   (ram_clock),
		.RESET       (RESET),
		.boot_done_i (boot_done_i),
		.reset_key_i (reset_key_i),
		.dl_active_i (dl_active_i),
		.erasing_i   (erasing),
		.cpu_ena_o   (cpu_ena_o),
		.cpu_reset_o (cpu_reset),
		.cpu_wait_o  (cpu_wait_o)
	);

	ram_eraser #(.RAM_ADDR_W(RAM_ADDR_W)) u_ram_eraser (
		.ram_clock       (ram_clock),
		.RESET           (RESET),
		.erase_trigger_i (erase_trigger_i),
		.erasing_o       (erasing),
		.mem             (erase_port.requester)
	);

	sysram_arbiter #(.RAM_ADDR_W(RAM_ADDR_W)) u_sysram_arbiter (
		.ram_clock   (ram_clock),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.erase_port  (erase_port.arbiter),
		.cpu_port    (cpu_port.arbiter)
	);

	// decoder runs off the cpu reset, not the system one
	io_decoder #(.RAM_ADDR_W(RAM_ADDR_W)) u_io_decoder (
		.ram_clock   (ram_clock),
		.cpu_reset_i (cpu_reset),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_dout_i  (cpu_dout_i),
		.cpu_rd_i    (cpu_rd_i),
		.cpu_wr_i    (cpu_wr_i),
		.cpu_mreq_i  (cpu_mreq_i),
		.cpu_iorq_i  (cpu_iorq_i),
		.cpu_din_o   (cpu_din_o),
		.led_o       (led_o),
		.mem         (cpu_port.requester)
	);

	assign erasing_o   = erasing;
	assign cpu_reset_o = cpu_reset;

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic ram_clock,
	output logic RESET
);

	initial begin
		ram_clock = 1'b0;
		forever #(PERIOD_NS / 2) ram_clock = ~ram_clock;
	end

	// reset drops on a falling edge, like every other input
	initial begin
		RESET = 1'b1;
		repeat (RESET_CYCLES) @(posedge ram_clock);
		@(negedge ram_clock);
		RESET = 1'b0;
	end

endmodule

/* bench/lm80c_tb.sv */
`timescale 1ns/1ps

module lm80c_tb;

	localparam int RAM_ADDR_W = 16;
	localparam int N_LOC = 12;
	// strobes held past the documented latency
	localparam int MEM_RD_HOLD = 5;
	localparam int MEM_WR_HOLD = 3;
	localparam int IO_HOLD = 3;
	localparam int RESET_TIMEOUT = 16;
	localparam int ERASE_TIMEOUT = 2 ** RAM_ADDR_W + 64;
	localparam int DRAIN_TIMEOUT = 8;

	logic ram_clock;
	logic RESET;

	lm80c_bus_pkg::cpu_addr_t cpu_addr;
	lm80c_bus_pkg::cpu_data_t cpu_dout;
	logic cpu_rd;
	logic cpu_wr;
	logic cpu_mreq;
	logic cpu_iorq;
	logic dl_active;
	logic dl_wr;
	logic [RAM_ADDR_W-1:0] dl_addr;
	lm80c_bus_pkg::cpu_data_t dl_data;
	logic boot_done;
	logic reset_key;
	logic erase_trigger;
	lm80c_bus_pkg::cpu_data_t cpu_din;
	logic cpu_ena;
	logic cpu_reset;
	logic cpu_wait;
	logic erasing;
	logic led;

	// reference ram contents, keyed by address
	logic [7:0] shadow [logic [15:0]];

	// pending comparisons, pushed by the stimulus
	string what_q [$];
	logic [7:0] got_q [$];
	logic [7:0] exp_q [$];

	int checks = 0;
	int value_errors = 0;
	int timeout_errors = 0;

	// raised when a wait gives up
	event abort_ev;

	tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clock_gen (
		.ram_clock (ram_clock),
		.RESET     (RESET)
	);

	lm80c_core #(.RAM_ADDR_W(RAM_ADDR_W)) dut (
		.ram_clock       (ram_clock),
		.RESET           (RESET),
		.cpu_addr_i      (cpu_addr),
		.cpu_dout_i      (cpu_dout),
		.cpu_rd_i        (cpu_rd),
		.cpu_wr_i        (cpu_wr),
		.cpu_mreq_i      (cpu_mreq),
		.cpu_iorq_i      (cpu_iorq),
		.dl_active_i     (dl_active),
		.dl_wr_i         (dl_wr),
		.dl_addr_i       (dl_addr),
		.dl_data_i       (dl_data),
		.boot_done_i     (boot_done),
		.reset_key_i     (reset_key),
		.erase_trigger_i (erase_trigger),
		.cpu_din_o       (cpu_din),
		.cpu_ena_o       (cpu_ena),
		.cpu_reset_o     (cpu_reset),
		.cpu_wait_o      (cpu_wait),
		.erasing_o       (erasing),
		.led_o           (led)
	);

	// numerical recipes lcg
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected byte for a cpu memory read
	function automatic logic [7:0] ref_read(input logic [15:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return 8'hxx;
	endfunction

	// cpu writes only land inside the ram window
	function automatic logic in_cpu_window(input logic [15:0] a);
		return (a >= lm80c_bus_pkg::RAM_WIN_LO) && (a <= lm80c_bus_pkg::RAM_WIN_HI);
	endfunction

	// {reset, wait} from the halt conditions
	function automatic logic [1:0] ref_ctrl(input logic boot, input logic key,
		input logic dl, input logic ers);
		return {~boot | key | ers, ~boot | dl | ers};
	endfunction

	// sample n sits n+1 clocks after the first edge with RESET low
	function automatic logic ref_ena(input int n);
		return ((n + 1) % lm80c_bus_pkg::CPU_ENA_PERIOD) == 0;
	endfunction

	task automatic expect_value(input string what, input logic [7:0] got, input logic [7:0] exp);
		what_q.push_back(what);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	// comparator, drains whatever was queued since the last clock
	always @(negedge ram_clock) begin
		string what;
		logic [7:0] got;
		logic [7:0] exp;
		while (got_q.size() != 0) begin
			what = what_q.pop_front();
			got = got_q.pop_front();
			exp = exp_q.pop_front();
			checks++;
			a_match: assert (got === exp) else begin
				value_errors++;
				$display("Fail %0d ns: %s gave %02h, expected %02h", $time, what, got, exp);
			end
		end
	end

	task automatic end_run();
		$display("checks %0d, value errors %0d, timeout errors %0d",
			checks, value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	// stimulus stays parked here, the abort process closes the run
	task automatic timed_out(input string what);
		timeout_errors++;
		$display("timed out waiting for %s", what);
		-> abort_ev;
		forever @(negedge ram_clock);
	endtask

	task automatic bus_idle();
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		cpu_mreq = 1'b0;
		cpu_iorq = 1'b0;
	endtask

	// one z80 style access, strobes stay put for hold clocks
	task automatic cpu_access(input logic [15:0] addr, input logic [7:0] data,
		input logic is_io, input logic is_wr, input int hold);
		@(negedge ram_clock);
		cpu_addr = addr;
		cpu_dout = data;
		cpu_iorq = is_io;
		cpu_mreq = ~is_io;
		cpu_wr = is_wr;
		cpu_rd = ~is_wr;
		repeat (hold) @(negedge ram_clock);
	endtask

	task automatic mem_read(input logic [15:0] addr, output logic [7:0] data);
		cpu_access(addr, 8'h00, 1'b0, 1'b0, MEM_RD_HOLD);
		data = cpu_din;
		bus_idle();
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_access(addr, data, 1'b0, 1'b1, MEM_WR_HOLD);
		bus_idle();
	endtask

	task automatic io_read(input logic [15:0] addr, output logic [7:0] data);
		cpu_access(addr, 8'h00, 1'b1, 1'b0, IO_HOLD);
		data = cpu_din;
		bus_idle();
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_access(addr, data, 1'b1, 1'b1, IO_HOLD);
		bus_idle();
	endtask

	// one download beat, dl_active is handled by the caller
	task automatic dl_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge ram_clock);
		dl_wr = 1'b1;
		dl_addr = addr;
		dl_data = data;
		@(negedge ram_clock);
		dl_wr = 1'b0;
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		@(posedge ram_clock);
		while (RESET !== 1'b0 && n < RESET_TIMEOUT) begin
			@(posedge ram_clock);
			n++;
		end
		if (RESET !== 1'b0) begin
			timed_out("RESET to be released");
		end
	endtask

	task automatic wait_erase_done();
		int n;
		n = 0;
		while (erasing !== 1'b0 && n < ERASE_TIMEOUT) begin
			@(negedge ram_clock);
			n++;
		end
		if (erasing !== 1'b0) begin
			timed_out("erasing_o to fall");
		end
	endtask

	task automatic drain_checks();
		int n;
		n = 0;
		while (got_q.size() != 0 && n < DRAIN_TIMEOUT) begin
			@(negedge ram_clock);
			n++;
		end
		if (got_q.size() != 0) begin
			timed_out("the comparator to empty its queue");
		end
	endtask

	// ends the run once a wait gives up
	initial begin
		@(abort_ev);
		end_run();
	end

	initial begin
		logic [31:0] rng;
		logic [7:0] rd_byte;
		logic [7:0] led_byte;
		logic [7:0] other_port;
		logic [1:0] exp_ctrl;
		logic [15:0] loc [N_LOC];
		rng = 32'hf73f_b95e;
		cpu_addr = '0;
		cpu_dout = '0;
		bus_idle();
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		boot_done = 1'b0;
		reset_key = 1'b0;
		erase_trigger = 1'b0;

		// enable cadence right after reset
		wait_reset_release();
		for (int i = 0; i < 6 * lm80c_bus_pkg::CPU_ENA_PERIOD; i++) begin
			@(negedge ram_clock);
			expect_value("cpu_ena_o", {7'b0, cpu_ena}, {7'b0, ref_ena(i)});
		end

		// every combination of the halt inputs, eraser idle
		for (int c = 0; c < 8; c++) begin
			@(negedge ram_clock);
			boot_done = c[0];
			reset_key = c[1];
			dl_active = c[2];
			// combinational, so look before the next rising edge
			#1;
			exp_ctrl = ref_ctrl(boot_done, reset_key, dl_active, 1'b0);
			expect_value($sformatf("cpu_reset_o case %0d", c), {7'b0, cpu_reset},
				{7'b0, exp_ctrl[1]});
			expect_value($sformatf("cpu_wait_o case %0d", c), {7'b0, cpu_wait},
				{7'b0, exp_ctrl[0]});
		end
		@(negedge ram_clock);
		boot_done = 1'b0;
		reset_key = 1'b0;
		dl_active = 1'b0;

		// locations below, inside and above the cpu window
		for (int i = 0; i < N_LOC; i++) begin
			rng = lcg_step(rng);
			case (i % 3)
				0: loc[i] = 16'h8000 | (rng[31:16] & 16'h3fff);
				1: loc[i] = {1'b0, rng[30:16]};
				default: loc[i] = 16'hc000 | (rng[31:16] & 16'h3fff);
			endcase
		end

		// download while the cpu is still held in boot
		@(negedge ram_clock);
		dl_active = 1'b1;
		for (int i = 0; i < N_LOC; i++) begin
			rng = lcg_step(rng);
			shadow[loc[i]] = rng[23:16];
			dl_write(loc[i], rng[23:16]);
		end
		@(negedge ram_clock);
		dl_active = 1'b0;
		boot_done = 1'b1;
		for (int i = 0; i < N_LOC; i++) begin
			mem_read(loc[i], rd_byte);
			expect_value($sformatf("download read of %04h", loc[i]), rd_byte, ref_read(loc[i]));
		end

		// cpu writes, only the window ones should stick
		for (int i = 0; i < N_LOC; i++) begin
			rng = lcg_step(rng);
			mem_write(loc[i], rng[15:8]);
			if (in_cpu_window(loc[i])) begin
				shadow[loc[i]] = rng[15:8];
			end
		end
		for (int i = 0; i < N_LOC; i++) begin
			mem_read(loc[i], rd_byte);
			expect_value($sformatf("window read of %04h", loc[i]), rd_byte, ref_read(loc[i]));
		end

		// led latch, upper address byte is not decoded
		rng = lcg_step(rng);
		led_byte = rng[7:0] | 8'h01;
		other_port = rng[15:8] & 8'h7f;
		io_write({rng[23:16], lm80c_bus_pkg::LED_PORT}, led_byte);
		expect_value("led_o after nonzero write", {7'b0, led}, {7'b0, led_byte != 8'h00});
		io_read({8'h00, lm80c_bus_pkg::LED_PORT}, rd_byte);
		expect_value("led port read", rd_byte, led_byte);
		io_read({8'h00, other_port}, rd_byte);
		expect_value($sformatf("read of port %02h", other_port), rd_byte, 8'h00);
		io_write({8'h00, lm80c_bus_pkg::LED_PORT}, 8'h00);
		expect_value("led_o after zero write", {7'b0, led}, 8'h00);
		io_write({8'h00, lm80c_bus_pkg::LED_PORT}, led_byte);

		// erase sweep, single clock trigger pulse
		@(negedge ram_clock);
		erase_trigger = 1'b1;
		@(negedge ram_clock);
		exp_ctrl = ref_ctrl(boot_done, reset_key, dl_active, 1'b1);
		expect_value("erasing_o after trigger", {7'b0, erasing}, 8'h01);
		expect_value("cpu_reset_o while erasing", {7'b0, cpu_reset}, {7'b0, exp_ctrl[1]});
		expect_value("cpu_wait_o while erasing", {7'b0, cpu_wait}, {7'b0, exp_ctrl[0]});
		erase_trigger = 1'b0;
		wait_erase_done();
		foreach (shadow[a]) begin
			shadow[a] = lm80c_mem_pkg::ERASE_VALUE;
		end
		// latch was cleared while the cpu sat in reset
		expect_value("led_o after erase", {7'b0, led}, 8'h00);
		for (int i = 0; i < N_LOC; i++) begin
			mem_read(loc[i], rd_byte);
			expect_value($sformatf("erased read of %04h", loc[i]), rd_byte, ref_read(loc[i]));
		end

		drain_checks();
		end_run();
	end

endmodule

/* sources.f */
hw/lm80c_bus_pkg.sv
hw/lm80c_mem_pkg.sv
hw/mem_port_if.sv
hw/system_control.sv
hw/ram_eraser.sv
hw/sysram_arbiter.sv
hw/io_decoder.sv
hw/lm80c_core.sv
bench/tb_clock_gen.sv
bench/lm80c_tb.sv

/* Makefile */
TOP := lm80c_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
